/* src/i3c_target_pkg.sv */
`default_nettype none

package i3c_target_pkg;

  // ----------------------------------------
  // Register file geometry
  // ----------------------------------------

  // Number of byte registers behind the target
  localparam int REG_DEPTH = 16;

  // Register index wide enough for REG_DEPTH entries
  typedef logic [$clog2(REG_DEPTH)-1:0] reg_addr_t;

  // One register byte
  typedef logic [7:0] reg_data_t;

  // Seven bit static bus address
  typedef logic [6:0] tgt_addr_t;

  // Address this target answers to
  localparam tgt_addr_t TARGET_ADDR = 7'h2a;

  // ----------------------------------------
  // Monitor to driver events
  // ----------------------------------------

  // Single cycle strobes except bit_val which holds the last sample
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic byte_done;
    logic bit_val;
  } i3c_bus_evt_t;

  // Bus side register write request
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    reg_data_t data;
  } reg_wr_t;

  // Driver protocol states
  typedef enum logic [3:0] {
    IDLE,
    ADDR,
    ADDR_ACK,
    PTR,
    PTR_ACK,
    WDATA,
    WDATA_ACK,
    RDATA,
    RDATA_ACK,
    IGNORE
  } drv_state_t;

endpackage : i3c_target_pkg

`default_nettype wire

/* src/i3c_target_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module i3c_target_monitor (
  input  wire                          pclk,
  input  wire                          rst_n_i,
  input  wire                          scl_i,
  input  wire                          sda_i,
  output i3c_target_pkg::i3c_bus_evt_t evt_o,
  output i3c_target_pkg::reg_data_t    rx_byte_o
);

  import i3c_target_pkg::*;

  // ----------------------------------------
  // Line synchronizers
  // ----------------------------------------

  // Index 1 is the settled copy of each line
  logic [1:0] scl_sync;
  logic [1:0] sda_sync;

  // Settled values from the previous cycle
  logic       scl_prev;
  logic       sda_prev;

  // Raw edge and condition detects
  logic       scl_rise;
  logic       scl_fall;
  logic       start_det;
  logic       stop_det;

  // Receive shifter and bit position within the 9 bit slot
  reg_data_t  shift_q;
  logic [3:0] bit_cnt;
  logic       data_bit;

  // Idle bus is high so reset to 1 avoids a false START
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl_i};
      sda_sync <= {sda_sync[0], sda_i};
      scl_prev <= scl_sync[1];
      sda_prev <= sda_sync[1];
    end
  end

  assign scl_rise = scl_sync[1] & ~scl_prev;
  assign scl_fall = ~scl_sync[1] & scl_prev;

  // SDA moves while SCL stays high on both samples
  assign start_det = ~sda_sync[1] & sda_prev & scl_sync[1] & scl_prev;
  assign stop_det  = sda_sync[1] & ~sda_prev & scl_sync[1] & scl_prev;

  // Data bits shift in but the ACK slot does not
  assign data_bit = scl_rise & (bit_cnt != 4'd8);

  // ----------------------------------------
  // Event register
  // ----------------------------------------

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      evt_o   <= '0;
      bit_cnt <= '0;
    end else begin
      evt_o.start     <= start_det;
      evt_o.stop      <= stop_det;
      evt_o.scl_rise  <= scl_rise;
      evt_o.scl_fall  <= scl_fall;
      evt_o.byte_done <= data_bit & (bit_cnt == 4'd7);
      // Sampled level of SDA at every SCL rise
      if (scl_rise) begin
        evt_o.bit_val <= sda_sync[1];
      end
      if (start_det || stop_det) begin
        bit_cnt <= '0;
      end else if (scl_rise) begin
        // Wrap after the ninth bit
        bit_cnt <= (bit_cnt == 4'd8) ? 4'd0 : bit_cnt + 4'd1;
      end
    end
  end

  // Byte assembly with the MSB first
  always_ff @(posedge pclk) begin
    if (data_bit) begin
      shift_q <= {shift_q[6:0], sda_sync[1]};
      if (bit_cnt == 4'd7) begin
        rx_byte_o <= {shift_q[6:0], sda_sync[1]};
      end
    end
  end

endmodule : i3c_target_monitor

`default_nettype wire

/* src/i3c_target_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module i3c_target_driver (
  input  wire                               pclk,
  input  wire                               rst_n_i,
  input  wire i3c_target_pkg::i3c_bus_evt_t evt_i,
  input  wire i3c_target_pkg::reg_data_t    rx_byte_i,
  input  wire i3c_target_pkg::reg_data_t    rd_data_i,
  output i3c_target_pkg::reg_addr_t         rd_addr_o,
  output i3c_target_pkg::reg_wr_t           bus_wr_o,
  output logic                              sda_oe_o
);

  import i3c_target_pkg::*;

  drv_state_t state;

  // Register pointer kept across frames
  reg_addr_t  ptr;
  // Direction bit latched from the address byte
  logic       rnw;

  // Read data shifter and count of bits already sent
  reg_data_t  tx_shift;
  logic [2:0] tx_cnt;

  // Qualified strobes with START and STOP taking precedence
  logic       bus_ok;
  logic       tx_load;
  logic       tx_step;
  logic       wr_hit;

  assign bus_ok = ~evt_i.start & ~evt_i.stop;

  // New byte at end of address ACK or after a controller ACK
  assign tx_load = bus_ok & evt_i.scl_fall &
                   (((state == ADDR_ACK) & sda_oe_o & rnw) | (state == RDATA_ACK));

  // Next bit of the current read byte
  assign tx_step = bus_ok & evt_i.scl_fall & (state == RDATA) & (tx_cnt != 3'd7);

  // Data byte of a write frame
  assign wr_hit = bus_ok & evt_i.byte_done & (state == WDATA);

  assign rd_addr_o = ptr;

  always_comb begin
    bus_wr_o.en   = wr_hit;
    bus_wr_o.addr = ptr;
    bus_wr_o.data = rx_byte_i;
  end

  // ----------------------------------------
  // Protocol FSM
  // ----------------------------------------

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      state    <= IDLE;
      ptr      <= '0;
      rnw      <= 1'b0;
      sda_oe_o <= 1'b0;
      tx_cnt   <= '0;
    end else if (evt_i.start) begin
      // START or repeated START always restarts address phase
      state    <= ADDR;
      sda_oe_o <= 1'b0;
    end else if (evt_i.stop) begin
      state    <= IDLE;
      sda_oe_o <= 1'b0;
    end else begin
      case (state)
        ADDR: begin
          if (evt_i.byte_done) begin
            if (rx_byte_i[7:1] == TARGET_ADDR) begin
              state <= ADDR_ACK;
              rnw   <= rx_byte_i[0];
            end else begin
              state <= IGNORE;
            end
          end
        end
        ADDR_ACK: begin
          if (evt_i.scl_fall) begin
            if (!sda_oe_o) begin
              // Pull low for the ACK slot
              sda_oe_o <= 1'b1;
            end else if (rnw) begin
              state    <= RDATA;
              sda_oe_o <= ~rd_data_i[7];
              tx_cnt   <= '0;
              ptr      <= ptr + 1'b1;
            end else begin
              state    <= PTR;
              sda_oe_o <= 1'b0;
            end
          end
        end
        PTR: begin
          if (evt_i.byte_done) begin
            ptr   <= reg_addr_t'(rx_byte_i);
            state <= PTR_ACK;
          end
        end
        WDATA: begin
          if (wr_hit) begin
            ptr   <= ptr + 1'b1;
            state <= WDATA_ACK;
          end
        end
        PTR_ACK, WDATA_ACK: begin
          if (evt_i.scl_fall) begin
            if (!sda_oe_o) begin
              sda_oe_o <= 1'b1;
            end else begin
              sda_oe_o <= 1'b0;
              state    <= WDATA;
            end
          end
        end
        RDATA: begin
          if (tx_step) begin
            sda_oe_o <= ~tx_shift[6];
            tx_cnt   <= tx_cnt + 1'b1;
          end else if (evt_i.scl_fall) begin
            // Last bit sent so release for the controller ACK
            sda_oe_o <= 1'b0;
            state    <= RDATA_ACK;
          end
        end
        RDATA_ACK: begin
          if (evt_i.scl_rise && evt_i.bit_val) begin
            // NACK ends the read
            state <= IDLE;
          end else if (tx_load) begin
            state    <= RDATA;
            sda_oe_o <= ~rd_data_i[7];
            tx_cnt   <= '0;
            ptr      <= ptr + 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Read byte shifter where the MSB leaves first
  always_ff @(posedge pclk) begin
    if (tx_load) begin
      tx_shift <= rd_data_i;
    end else if (tx_step) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

endmodule : i3c_target_driver

`default_nettype wire

/* src/i3c_target_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module i3c_target_regfile (
  input  wire                          pclk,
  input  wire                          rst_n_i,
  input  wire i3c_target_pkg::reg_wr_t   bus_wr_i,
  input  wire i3c_target_pkg::reg_addr_t rd_addr_i,
  output i3c_target_pkg::reg_data_t      rd_data_o,
  input  wire                          wb_cyc_i,
  input  wire                          wb_stb_i,
  input  wire                          wb_we_i,
  input  wire i3c_target_pkg::reg_addr_t wb_adr_i,
  input  wire i3c_target_pkg::reg_data_t wb_dat_i,
  output i3c_target_pkg::reg_data_t      wb_dat_o,
  output logic                         wb_ack_o
);

  import i3c_target_pkg::*;

  reg_data_t mem [REG_DEPTH];

  // New request only when no ack is out so transfers get one idle cycle between them
  logic wb_req;
  logic wb_wr;
  // Bus write to the same register wins
  logic wb_blocked;

  assign wb_req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wb_blocked = bus_wr_i.en & (bus_wr_i.addr == wb_adr_i);
  assign wb_wr      = wb_req & wb_we_i & ~wb_blocked;

  // Asynchronous read port for the driver
  assign rd_data_o = mem[rd_addr_i];

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      for (int i = 0; i < REG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      wb_ack_o <= wb_req;
      if (wb_wr) begin
        mem[wb_adr_i] <= wb_dat_i;
      end
      if (bus_wr_i.en) begin
        mem[bus_wr_i.addr] <= bus_wr_i.data;
      end
    end
  end

  // Read data captured with the request stays valid while ack is high
  always_ff @(posedge pclk) begin
    if (wb_req) begin
      wb_dat_o <= mem[wb_adr_i];
    end
  end

endmodule : i3c_target_regfile

`default_nettype wire

/* src/i3c_target_agent.sv */
`timescale 1ns/1ps
`default_nettype none

module i3c_target_agent (
  input  wire                            pclk,
  input  wire                            rst_n_i,
  input  wire                            scl_i,
  input  wire                            sda_i,
  output wire                            sda_oe_o,
  input  wire                            wb_cyc_i,
  input  wire                            wb_stb_i,
  input  wire                            wb_we_i,
  input  wire i3c_target_pkg::reg_addr_t wb_adr_i,
  input  wire i3c_target_pkg::reg_data_t wb_dat_i,
  output wire i3c_target_pkg::reg_data_t wb_dat_o,
  output wire                            wb_ack_o
);

  import i3c_target_pkg::*;

  // Monitor to driver
  i3c_bus_evt_t evt;
  reg_data_t    rx_byte;

  // Driver to register file
  reg_wr_t      bus_wr;
  reg_addr_t    rd_addr;
  reg_data_t    rd_data;

  // ----------------------------------------
  // Bus monitor
  // ----------------------------------------

  i3c_target_monitor u_monitor (
    .pclk      (pclk),
    .rst_n_i   (rst_n_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .evt_o     (evt),
    .rx_byte_o (rx_byte)
  );

  // ----------------------------------------
  // Bus driver
  // ----------------------------------------

  // Only ever pulls SDA low, never touches SCL
  i3c_target_driver u_driver (
    .pclk      (pclk),
    .rst_n_i   (rst_n_i),
    .evt_i     (evt),
    .rx_byte_i (rx_byte),
    .rd_data_i (rd_data),
    .rd_addr_o (rd_addr),
    .bus_wr_o  (bus_wr),
    .sda_oe_o  (sda_oe_o)
  );

  // Shared register storage with the host port
  i3c_target_regfile u_regfile (
    .pclk      (pclk),
    .rst_n_i   (rst_n_i),
    .bus_wr_i  (bus_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o)
  );

endmodule : i3c_target_agent

`default_nettype wire

/* tb/i3c_target_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module i3c_target_sva (
  input wire                             pclk,
  input wire                             rst_n_i,
  input wire                             sda_oe_i,
  input wire i3c_target_pkg::drv_state_t drv_state_i,
  input wire                             wb_cyc_i,
  input wire                             wb_stb_i,
  input wire                             wb_ack_i
);

  import i3c_target_pkg::*;

  // Set once the driver reaches its first address ACK
  logic addr_ack_seen;

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      addr_ack_seen <= 1'b0;
    end else if (drv_state_i == ADDR_ACK) begin
      addr_ack_seen <= 1'b1;
    end
  end

  // ----------------------------------------
  // SDA drive
  // ----------------------------------------

  a_oe_reset: assert property (@(posedge pclk) !rst_n_i |=> !sda_oe_i)
    else $error("sda_oe_o high after a reset cycle");

  a_oe_before_ack: assert property (@(posedge pclk) rst_n_i && !addr_ack_seen |-> !sda_oe_i)
    else $error("sda_oe_o high before the first address ACK");

  // ----------------------------------------
  // Wishbone handshake
  // ----------------------------------------

  a_ack_single: assert property (@(posedge pclk) disable iff (!rst_n_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("wb_ack_o high two cycles in a row");

  a_ack_requested: assert property (@(posedge pclk) disable iff (!rst_n_i)
    $rose(wb_ack_i) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o rose without cyc and stb");

endmodule : i3c_target_sva

bind i3c_target_agent i3c_target_sva u_sva (
  .pclk        (pclk),
  .rst_n_i     (rst_n_i),
  .sda_oe_i    (sda_oe_o),
  .drv_state_i (u_driver.state),
  .wb_cyc_i    (wb_cyc_i),
  .wb_stb_i    (wb_stb_i),
  .wb_ack_i    (wb_ack_o)
);

`default_nettype wire

/* tb/i3c_target_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module i3c_target_tb;

  import i3c_target_pkg::*;

  localparam int CLK_PERIOD = 100;
  // Rounds per test and an upper bound on the bus bits of one round
  localparam int ROUNDS = 6;
  localparam int ROUND_BITS = 128;
  // Five tests at 16 pclk per bus bit plus a margin for reset and Wishbone traffic
  localparam int WATCHDOG_CYCLES = 5 * ROUNDS * ROUND_BITS * 16 + 5000;
  localparam int WB_TIMEOUT = 8;

  logic      pclk;
  logic      rst_n_i;
  // Controller side of the open-drain lines where 1 means released
  logic      scl_ctl;
  logic      sda_ctl;
  logic      sda_oe;
  logic      sda_line;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  reg_addr_t wb_adr;
  reg_data_t wb_dat_wr;
  reg_data_t wb_dat_rd;
  logic      wb_ack;

  // Reference model of the register file and pointer
  reg_data_t ref_mem [REG_DEPTH];
  reg_addr_t ref_ptr;

  logic [31:0] rng_state;
  int          err_count;
  int          check_count;
  int          test_count;
  int          fail_tests;

  // Wired AND of controller and target
  assign sda_line = sda_ctl & ~sda_oe;

  always #(CLK_PERIOD / 2) pclk = ~pclk;

  i3c_target_agent dut0 (
    .pclk     (pclk),
    .rst_n_i  (rst_n_i),
    .scl_i    (scl_ctl),
    .sda_i    (sda_line),
    .sda_oe_o (sda_oe),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_wr),
    .wb_dat_o (wb_dat_rd),
    .wb_ack_o (wb_ack)
  );

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge pclk);
    #1;
  endtask

  task automatic compare_byte(input string sig, input reg_addr_t idx,
                              input reg_data_t got, input reg_data_t want);
    check_count++;
    assert (got === want) else begin
      $display("error: %s[%0h] got %02h expected %02h", sig, idx, got, want);
      err_count++;
    end
  endtask

  task automatic check_ack(input logic acked, input logic want, input string what);
    check_count++;
    assert (acked == want) else begin
      if (want) begin
        $display("target did not acknowledge the %s byte", what);
      end else begin
        $display("target acknowledged the %s byte it should ignore", what);
      end
      err_count++;
    end
  endtask

  // ----------------------------------------
  // Bus controller model
  // ----------------------------------------

  // One bit slot of 8 pclk low and 8 pclk high with the sample taken at the end of high
  task automatic clock_bit(input logic b, output logic s);
    wait_cycles(2);
    sda_ctl = b;
    wait_cycles(6);
    scl_ctl = 1'b1;
    wait_cycles(8);
    s = sda_line;
    scl_ctl = 1'b0;
  endtask

  // Also serves as repeated START when SCL is low
  task automatic start_cond();
    wait_cycles(2);
    sda_ctl = 1'b1;
    wait_cycles(6);
    scl_ctl = 1'b1;
    wait_cycles(8);
    sda_ctl = 1'b0;
    wait_cycles(8);
    scl_ctl = 1'b0;
  endtask

  task automatic stop_cond();
    wait_cycles(2);
    sda_ctl = 1'b0;
    wait_cycles(6);
    scl_ctl = 1'b1;
    wait_cycles(8);
    sda_ctl = 1'b1;
    wait_cycles(8);
  endtask

  // MSB first and then the released ACK slot
  task automatic send_byte(input reg_data_t b, output logic acked);
    reg_data_t sh;
    logic      s;
    sh = b;
    repeat (8) begin
      clock_bit(sh[7], s);
      sh = {sh[6:0], 1'b0};
    end
    clock_bit(1'b1, s);
    acked = ~s;
  endtask

  task automatic recv_byte(input logic nack, output reg_data_t d);
    logic s;
    d = '0;
    repeat (8) begin
      clock_bit(1'b1, s);
      d = {d[6:0], s};
    end
    clock_bit(nack, s);
  endtask

  // Pointer byte then data with the model following each acknowledged byte
  task automatic write_frame(input reg_addr_t ptr, input int nbytes);
    logic      acked;
    reg_data_t d;
    start_cond();
    send_byte({TARGET_ADDR, 1'b0}, acked);
    check_ack(acked, 1'b1, "address");
    // Upper nibble of the pointer byte is don't care
    d = reg_data_t'(xorshift32());
    send_byte({d[3:0], ptr}, acked);
    check_ack(acked, 1'b1, "pointer");
    ref_ptr = ptr;
    repeat (nbytes) begin
      d = reg_data_t'(xorshift32());
      send_byte(d, acked);
      check_ack(acked, 1'b1, "write data");
      ref_mem[ref_ptr] = d;
      ref_ptr = ref_ptr + 1'b1;
    end
    stop_cond();
  endtask

  // Optional pointer write and repeated START before a read that ends in NACK
  task automatic read_frame(input logic set_ptr, input reg_addr_t ptr, input int nbytes);
    logic      acked;
    reg_data_t d;
    start_cond();
    if (set_ptr) begin
      send_byte({TARGET_ADDR, 1'b0}, acked);
      check_ack(acked, 1'b1, "address");
      send_byte({4'h0, ptr}, acked);
      check_ack(acked, 1'b1, "pointer");
      ref_ptr = ptr;
      start_cond();
    end
    send_byte({TARGET_ADDR, 1'b1}, acked);
    check_ack(acked, 1'b1, "read address");
    for (int k = 0; k < nbytes; k++) begin
      recv_byte(k == nbytes - 1, d);
      compare_byte("sda_i", ref_ptr, d, ref_mem[ref_ptr]);
      ref_ptr = ref_ptr + 1'b1;
    end
    stop_cond();
  endtask

  // ----------------------------------------
  // Wishbone host model
  // ----------------------------------------

  task automatic host_access(input logic we, input reg_addr_t adr,
                             input reg_data_t wdat, output reg_data_t rdat);
    int waited;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = adr;
    wb_dat_wr = wdat;
    waited    = 0;
    wait_cycles(1);
    while (!wb_ack && waited < WB_TIMEOUT) begin
      wait_cycles(1);
      waited++;
    end
    assert (wb_ack) else begin
      $display("Wishbone access to register %0h never got an ack", adr);
      err_count++;
    end
    // Read data valid while ack is high
    rdat   = wb_dat_rd;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic host_write(input reg_addr_t adr, input reg_data_t dat);
    reg_data_t unused;
    host_access(1'b1, adr, dat, unused);
    ref_mem[adr] = dat;
  endtask

  task automatic check_all_regs();
    reg_addr_t a;
    reg_data_t got;
    a = '0;
    repeat (REG_DEPTH) begin
      host_access(1'b0, a, '0, got);
      compare_byte("wb_dat_o", a, got, ref_mem[a]);
      a = a + 1'b1;
    end
  endtask

  task automatic end_test(input string name, input int mark);
    test_count++;
    if (err_count == mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - mark);
      fail_tests++;
    end
  endtask

  // Bounds the run if the DUT or a model hangs
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int        mark;
    int        n;
    reg_addr_t p;
    reg_data_t d;
    logic      acked;
    tgt_addr_t foreign;

    pclk        = 1'b0;
    rst_n_i     = 1'b0;
    scl_ctl     = 1'b1;
    sda_ctl     = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_wr   = '0;
    rng_state   = 32'habc0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    fail_tests  = 0;
    foreach (ref_mem[i]) begin
      ref_mem[i] = '0;
    end
    ref_ptr = '0;

    wait_cycles(16);
    rst_n_i = 1'b1;
    wait_cycles(2);

    // All zero after reset and the bus read starts at pointer 0
    mark = err_count;
    check_all_regs();
    read_frame(1'b0, '0, 1);
    end_test("reset_values", mark);

    // First frame wraps the pointer past 15
    mark = err_count;
    write_frame(4'hd, 6);
    repeat (ROUNDS - 1) begin
      p = reg_addr_t'(xorshift32());
      n = 1 + int'(xorshift32() % 32'd6);
      write_frame(p, n);
    end
    check_all_regs();
    end_test("bus_write_wb_readback", mark);

    mark = err_count;
    repeat (ROUNDS) begin
      repeat (4) begin
        p = reg_addr_t'(xorshift32());
        d = reg_data_t'(xorshift32());
        host_write(p, d);
      end
      p = reg_addr_t'(xorshift32());
      n = 1 + int'(xorshift32() % 32'd8);
      read_frame(1'b1, p, n);
    end
    end_test("wb_write_bus_read", mark);

    // Target stays silent and registers keep their values
    mark = err_count;
    repeat (ROUNDS) begin
      foreign = tgt_addr_t'(xorshift32());
      if (foreign == TARGET_ADDR) begin
        foreign = foreign ^ 7'h01;
      end
      d = reg_data_t'(xorshift32());
      start_cond();
      send_byte({foreign, d[0]}, acked);
      check_ack(acked, 1'b0, "foreign address");
      repeat (2) begin
        send_byte(reg_data_t'(xorshift32()), acked);
        check_ack(acked, 1'b0, "foreign data");
      end
      stop_cond();
    end
    check_all_regs();
    end_test("foreign_address", mark);

    // Reads continue from wherever the last transfer left the pointer
    mark = err_count;
    repeat (ROUNDS) begin
      n = 1 + int'(xorshift32() % 32'd4);
      read_frame(1'b0, '0, n);
    end
    end_test("pointer_persistence", mark);

    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             test_count, fail_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : i3c_target_tb

`default_nettype wire

/* tb.f */
src/i3c_target_pkg.sv
src/i3c_target_monitor.sv
src/i3c_target_driver.sv
src/i3c_target_regfile.sv
src/i3c_target_agent.sv
tb/i3c_target_sva.sv
tb/i3c_target_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the I3C target testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module i3c_target_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "run.sh: compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vi3c_target_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "run.sh: simulation exited with status $status"
  exit 1
fi

if grep -q "TB PASSED" <<< "$output"; then
  echo "run.sh: simulation passed"
  exit 0
fi

echo "run.sh: simulation did not pass"
exit 1
